// ==== logic/dct_defs.svh ====
`ifndef DCT_DEFS_SVH
`define DCT_DEFS_SVH

// Points per 1-D transform
`define DCT_N       8

// Input pixel width
`define PIXEL_W     8

// Rounded row and block results
`define COEF_W      11

// Signed cosine constants, Q14
`define COS_W       15
`define FRAC_BITS   14

// Wide enough for eight 11-bit by 15-bit products
`define ACC_W       32

// Subtracted from every unsigned pixel
`define LEVEL_SHIFT 128

`endif

// ==== logic/dct_pkg.sv ====
`include "dct_defs.svh"

package dct_pkg;

    // Raw pixel as it arrives from the source
    typedef logic [`PIXEL_W-1:0] pixel_t;

    // Level-shifted pixel, one extra bit for the sign
    typedef logic signed [`PIXEL_W:0] sample_t;

    typedef logic signed [`COS_W-1:0] cosine_t;
    typedef logic signed [`ACC_W-1:0] acc_t;
    typedef logic signed [`COEF_W-1:0] coef_t;

    // Indexed by frequency v
    typedef coef_t [`DCT_N-1:0] coef_row_t;

    // Indexed [u][v]
    typedef coef_row_t [`DCT_N-1:0] coef_block_t;

    // DC row weight, 1/(2*sqrt(2)) in Q14
    localparam int COS_DC = 5793;

    // Magnitude of cos(m*pi/16)/2 in Q14 for m in 1..7
    function automatic int cos_mag(input int m);
        int mag;
        case (m)
            1: mag = 8035;
            2: mag = 7568;
            3: mag = 6811;
            4: mag = 5793;
            5: mag = 4551;
            6: mag = 3135;
            7: mag = 1598;
            default: mag = 0;
        endcase
        return mag;
    endfunction

    // Entry [k][n] of the 8-point DCT-II matrix
    function automatic cosine_t dct_cos(input logic [2:0] k, input logic [2:0] n);
        int phase;
        int mag;
        logic neg;
        if (k == 3'd0) begin
            return cosine_t'(COS_DC);
        end
        // Angle (2n+1)*k*pi/16, folded into the first quadrant
        phase = ((2 * int'(n) + 1) * int'(k)) % 32;
        if (phase > 16) begin
            phase = 32 - phase;
        end
        neg = (phase > 8);
        if (neg) begin
            phase = 16 - phase;
        end
        mag = cos_mag(phase);
        if (neg) begin
            return cosine_t'(-mag);
        end
        return cosine_t'(mag);
    endfunction

endpackage

// ==== logic/mac_lane.sv ====
`timescale 1ns/1ps

`include "dct_defs.svh"

module mac_lane
    import dct_pkg::*;
#(
    parameter type sample_type = sample_t
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       en,
    input  logic       first,
    input  sample_type sample,
    input  cosine_t    weight,
    output acc_t       sum,
    output coef_t      rounded
);

    acc_t product;
    acc_t shifted;
    acc_t round_bit;

    // Both operands sign-extended to full accumulator width
    assign product = acc_t'(sample) * acc_t'(weight);

    // First sample of a group restarts the sum
    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (en) begin
            if (first) begin
                sum <= product;
            end else begin
                sum <= sum + product;
            end
        end
    end

    // Round half up at the Q14 point
    assign shifted   = sum >>> `FRAC_BITS;
    assign round_bit = acc_t'({1'b0, sum[`FRAC_BITS-1]});
    assign rounded   = coef_t'(shifted + round_bit);

endmodule

// ==== logic/row_transform.sv ====
`timescale 1ns/1ps

`include "dct_defs.svh"

module row_transform
    import dct_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      pix_valid,
    input  pixel_t    pixel,
    output logic      row_valid,
    output coef_row_t row
);

    logic [2:0] col;
    logic       first_col;
    logic       last_col;
    logic       row_done;
    sample_t    shifted;
    coef_row_t  lane_out;
    cosine_t    weight [`DCT_N];

    assign first_col = (col == 3'd0);
    assign last_col  = (col == 3'(`DCT_N - 1));

    // Centre the pixel range around zero
    assign shifted = sample_t'({1'b0, pixel}) - sample_t'(`LEVEL_SHIFT);

    // Column position within the current row
    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
        end else if (pix_valid) begin
            col <= col + 3'd1;
        end
    end

    // One lane per output frequency v
    for (genvar v = 0; v < `DCT_N; v++) begin : g_lane
        assign weight[v] = dct_cos(3'(v), col);

        mac_lane #(
            .sample_type(sample_t)
        ) u_lane (
            .clk    (clk),
            .rst    (rst),
            .en     (pix_valid),
            .first  (first_col),
            .sample (shifted),
            .weight (weight[v]),
            .sum    (),
            .rounded(lane_out[v])
        );
    end

    // Sums settle on the edge taking column 7
    always_ff @(posedge clk) begin
        if (rst) begin
            row_done  <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            row_done  <= pix_valid && last_col;
            row_valid <= row_done;
        end
    end

    // Lanes may already be loading the next row, sum is read before update
    always_ff @(posedge clk) begin
        if (row_done) begin
            row <= lane_out;
        end
    end

endmodule

// ==== logic/column_transform.sv ====
`timescale 1ns/1ps

`include "dct_defs.svh"

module column_transform
    import dct_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        row_valid,
    input  coef_row_t   row,
    output logic        block_valid,
    output coef_block_t block
);

    logic [2:0]  row_idx;
    logic        first_row;
    logic        last_row;
    logic        block_done;
    coef_block_t lane_out;
    cosine_t     weight [`DCT_N];

    assign first_row = (row_idx == 3'd0);
    assign last_row  = (row_idx == 3'(`DCT_N - 1));

    // Row position within the current block
    always_ff @(posedge clk) begin
        if (rst) begin
            row_idx <= '0;
        end else if (row_valid) begin
            row_idx <= row_idx + 3'd1;
        end
    end

    // Weight depends only on u and the incoming row index
    for (genvar u = 0; u < `DCT_N; u++) begin : g_weight
        assign weight[u] = dct_cos(3'(u), row_idx);
    end

    // Lane (u,v) accumulates element v of every row
    for (genvar u = 0; u < `DCT_N; u++) begin : g_u
        for (genvar v = 0; v < `DCT_N; v++) begin : g_v
            mac_lane #(
                .sample_type(coef_t)
            ) u_lane (
                .clk    (clk),
                .rst    (rst),
                .en     (row_valid),
                .first  (first_row),
                .sample (row[v]),
                .weight (weight[u]),
                .sum    (),
                .rounded(lane_out[u][v])
            );
        end
    end

    // Eighth row accumulated, deliver on the following edge
    always_ff @(posedge clk) begin
        if (rst) begin
            block_done  <= 1'b0;
            block_valid <= 1'b0;
        end else begin
            block_done  <= row_valid && last_row;
            block_valid <= block_done;
        end
    end

    // Held until the next block completes
    always_ff @(posedge clk) begin
        if (block_done) begin
            block <= lane_out;
        end
    end

endmodule

// ==== logic/dct_8x8.sv ====
`timescale 1ns/1ps

module dct_8x8
    import dct_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pix_valid,
    input  pixel_t      pixel,
    output logic        block_valid,
    output coef_block_t block
);

    logic      row_valid;
    coef_row_t row;

    // Horizontal pass, one row result per eight pixels
    row_transform u_row (
        .clk      (clk),
        .rst      (rst),
        .pix_valid(pix_valid),
        .pixel    (pixel),
        .row_valid(row_valid),
        .row      (row)
    );

    // Vertical pass over the eight row results
    column_transform u_column (
        .clk        (clk),
        .rst        (rst),
        .row_valid  (row_valid),
        .row        (row),
        .block_valid(block_valid),
        .block      (block)
    );

endmodule

// ==== testbench/tb_dct_8x8.sv ====
`timescale 1ns/1ps

`include "dct_defs.svh"

module tb_dct_8x8
    import dct_pkg::*;
();

    localparam int SHAPE_ANY  = 0;
    localparam int SHAPE_ZERO = 1;
    localparam int SHAPE_DC   = 2;

    logic        clk;
    logic        rst;
    logic        pix_valid;
    pixel_t      pixel;
    logic        block_valid;
    coef_block_t block;

    int          pix_buf [64];
    coef_block_t expected_q [$];
    string       name_q [$];
    int          shape_q [$];
    int          deadline_q [$];
    int          edge_count;
    int          pix_count;

    // DCT-II matrix in Q14 with rows by frequency k and columns by position n
    int cos_table [8][8] = '{
        '{ 5793,  5793,  5793,  5793,  5793,  5793,  5793,  5793},
        '{ 8035,  6811,  4551,  1598, -1598, -4551, -6811, -8035},
        '{ 7568,  3135, -3135, -7568, -7568, -3135,  3135,  7568},
        '{ 6811, -1598, -8035, -4551,  4551,  8035,  1598, -6811},
        '{ 5793, -5793, -5793,  5793,  5793, -5793, -5793,  5793},
        '{ 4551, -8035,  1598,  6811, -6811, -1598,  8035, -4551},
        '{ 3135, -7568,  7568, -3135, -3135,  7568, -7568,  3135},
        '{ 1598, -4551,  6811, -8035,  8035, -6811,  4551, -1598}
    };

    always #5 clk = ~clk;

    dct_8x8 dut (
        .clk        (clk),
        .rst        (rst),
        .pix_valid  (pix_valid),
        .pixel      (pixel),
        .block_valid(block_valid),
        .block      (block)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic coef_t round_q14(input longint a);
        longint q;
        q = (a >>> `FRAC_BITS) + ((a >>> (`FRAC_BITS - 1)) & longint'(1));
        return coef_t'(q);
    endfunction

    // Reference 2-D transform of pix_buf
    function automatic coef_block_t model_block();
        int          rows [8][8];
        longint      acc;
        coef_block_t z;
        for (int r = 0; r < 8; r++) begin
            for (int v = 0; v < 8; v++) begin
                acc = '0;
                for (int c = 0; c < 8; c++) begin
                    acc = acc + longint'(cos_table[v][c] *
                                         (pix_buf[r * 8 + c] - `LEVEL_SHIFT));
                end
                rows[r][v] = int'(round_q14(acc));
            end
        end
        for (int u = 0; u < 8; u++) begin
            for (int v = 0; v < 8; v++) begin
                acc = '0;
                for (int r = 0; r < 8; r++) begin
                    acc = acc + longint'(cos_table[u][r] * rows[r][v]);
                end
                z[u][v] = round_q14(acc);
            end
        end
        return z;
    endfunction

    task automatic fill_const(input int value);
        for (int i = 0; i < 64; i++) begin
            pix_buf[i] = value;
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < 64; i++) begin
            pix_buf[i] = int'($urandom_range(0, 255));
        end
    endtask

    task automatic send_block(input string name, input int shape, input bit gaps);
        int idle;
        expected_q.push_back(model_block());
        name_q.push_back(name);
        shape_q.push_back(shape);
        for (int i = 0; i < 64; i++) begin
            idle = 0;
            if (gaps && $urandom_range(0, 2) == 0) begin
                idle = int'($urandom_range(1, 4));
            end
            repeat (idle) begin
                @(posedge clk);
                pix_valid <= 1'b0;
            end
            @(posedge clk);
            pix_valid <= 1'b1;
            pixel     <= pixel_t'(pix_buf[i]);
        end
    endtask

    task automatic stop_stream();
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        assert (expected_q.size() == 0)
            else stop_run("Timed out waiting for the remaining blocks to come out");
    endtask

    task automatic check_block(input string name, input coef_block_t want, input int shape);
        if (shape == SHAPE_DC) begin
            assert (block[0][0] != '0)
                else stop_run($sformatf("%s has a zero DC coefficient where one was expected",
                    name));
        end
        for (int u = 0; u < 8; u++) begin
            for (int v = 0; v < 8; v++) begin
                if (shape == SHAPE_ZERO || (shape == SHAPE_DC && (u != 0 || v != 0))) begin
                    assert (block[u][v] == '0)
                        else stop_run($sformatf("[FAIL] %s coef[%0d][%0d] expected 0 actual %0d",
                            name, u, v, $signed(block[u][v])));
                end
                assert (block[u][v] === want[u][v])
                    else stop_run($sformatf("[FAIL] %s coef[%0d][%0d] expected %0d actual %0d",
                        name, u, v, $signed(want[u][v]), $signed(block[u][v])));
            end
        end
    endtask

    // Counts accepted pixels and matches every block_valid pulse
    always @(posedge clk) begin
        coef_block_t want;
        string       name;
        int          shape;
        if (rst) begin
            edge_count = 0;
            pix_count  = 0;
        end else begin
            edge_count = edge_count + 1;
            if (pix_valid) begin
                if (pix_count == 63) begin
                    // Pulse rises 3 edges later and is seen here one edge after that
                    deadline_q.push_back(edge_count + 4);
                    pix_count = 0;
                end else begin
                    pix_count = pix_count + 1;
                end
            end
            if (block_valid) begin
                assert (deadline_q.size() > 0 && expected_q.size() > 0)
                    else stop_run("block_valid pulsed with no completed block pending");
                assert (deadline_q[0] == edge_count)
                    else stop_run($sformatf("[FAIL] %s block_valid edge expected %0d actual %0d",
                        name_q[0], deadline_q[0], edge_count));
                void'(deadline_q.pop_front());
                want  = expected_q.pop_front();
                name  = name_q.pop_front();
                shape = shape_q.pop_front();
                check_block(name, want, shape);
            end
            if (deadline_q.size() > 0) begin
                assert (edge_count <= deadline_q[0])
                    else stop_run(
                        "block_valid did not pulse three edges after a block's last pixel");
            end
        end
    end

    initial begin
        void'($urandom(32'hbaf2179e));
        clk       = 1'b0;
        rst       = 1'b1;
        pix_valid = 1'b0;
        pixel     = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Idle after reset with no pixels sent
        repeat (20) begin
            @(posedge clk);
            assert (block_valid === 1'b0)
                else stop_run("block_valid was not low while no pixels were sent");
        end

        fill_const(128);
        send_block("mid_grey", SHAPE_ZERO, 1'b0);
        fill_const(0);
        send_block("all_zero", SHAPE_DC, 1'b0);
        fill_const(255);
        send_block("all_max", SHAPE_DC, 1'b0);
        stop_stream();
        wait_drain();

        for (int b = 0; b < 20; b++) begin
            fill_random();
            send_block($sformatf("back_to_back_%0d", b), SHAPE_ANY, 1'b0);
        end
        stop_stream();
        wait_drain();

        for (int b = 0; b < 20; b++) begin
            fill_random();
            send_block($sformatf("gapped_%0d", b), SHAPE_ANY, 1'b1);
        end
        stop_stream();
        wait_drain();

        // Quiet tail where the monitor catches any stray pulse
        repeat (20) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/dct_pkg.sv
logic/mac_lane.sv
logic/row_transform.sv
logic/column_transform.sv
logic/dct_8x8.sv
testbench/tb_dct_8x8.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_dct_8x8
FILELIST  = verilog.f

SOURCES   = $(wildcard logic/*.sv logic/*.svh testbench/*.sv)
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
